// ==== source/ahbPkg.sv ====
`default_nettype none

package ahbPkg;

    ////////////////////////////////////////
    // bus widths and address map
    ////////////////////////////////////////
    localparam int ADDR_W = 32;                         // haddr width
    localparam int DATA_W = 32;                         // hrdata / hwdata width

    localparam logic [DATA_W-1:0] BAD_DATA = 32'hdeadbeef; // unmapped read value

    localparam logic [7:0] REGION_RAM  = 8'h20;         // block ram
    localparam logic [7:0] REGION_GPIO = 8'h50;         // leds, switches, buttons
    localparam logic [7:0] REGION_DISP = 8'h52;         // seven-segment display

    ////////////////////////////////////////
    // bus encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,                                 // upper bit set = active
        SEQ    = 2'b11
    } htransE;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsizeE;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_GPIO,
        SEL_DISP,
        SEL_NOMAP                                       // no slave at this address
    } slaveSelE;

    typedef enum logic [3:0] {
        LED_REG = 4'h0,                                 // read/write
        SW_REG  = 4'h8,                                 // read only
        BTN_REG = 4'hC                                  // read only
    } gpioRegE;

    typedef enum logic [3:0] {
        HEX_REG   = 4'h0,                               // eight nibbles
        MASK_REG  = 4'h4,                               // digit enables
        POINT_REG = 4'h8                                // decimal points
    } dispRegE;

endpackage

`default_nettype wire

// ==== source/addrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module addrDecoder (
    input  logic [ahbPkg::ADDR_W-1:0] hAddr,    // address phase address
    output logic                      hSelRam,  // ram select
    output logic                      hSelGpio, // gpio select
    output logic                      hSelDisp, // display select
    output ahbPkg::slaveSelE          addrSel   // to response mux
);

    logic [7:0] region;                         // top address byte

    assign region = hAddr[ahbPkg::ADDR_W-1 -: 8];

    always_comb begin
        hSelRam  = 1'b0;
        hSelGpio = 1'b0;
        hSelDisp = 1'b0;
        addrSel  = ahbPkg::SEL_NOMAP;           // miss unless a region matches
        case (region)
            ahbPkg::REGION_RAM: begin
                hSelRam = 1'b1;
                addrSel = ahbPkg::SEL_RAM;
            end
            ahbPkg::REGION_GPIO: begin
                hSelGpio = 1'b1;
                addrSel  = ahbPkg::SEL_GPIO;
            end
            ahbPkg::REGION_DISP: begin
                hSelDisp = 1'b1;
                addrSel  = ahbPkg::SEL_DISP;
            end
            default: ;                          // unmapped, nobody selected
        endcase
    end

endmodule

`default_nettype wire

// ==== source/responseMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module responseMux (
    input  logic                      HCLK,
    input  logic                      rst,
    input  ahbPkg::slaveSelE          addrSel,   // from decoder, address phase
    input  logic [ahbPkg::DATA_W-1:0] ramRdata,
    input  logic [ahbPkg::DATA_W-1:0] gpioRdata,
    input  logic [ahbPkg::DATA_W-1:0] dispRdata,
    input  logic                      ramReady,
    input  logic                      gpioReady,
    input  logic                      dispReady,
    output logic [ahbPkg::DATA_W-1:0] hRdata,    // to master
    output logic                      hReady     // to master and all slaves
);

    ahbPkg::slaveSelE dataSel;                   // select for the current data phase

    // follow the address phase only when the bus moves on
    always_ff @(posedge HCLK) begin
        if (rst) begin
            dataSel <= ahbPkg::SEL_NOMAP;        // ready high out of reset
        end else if (hReady) begin
            dataSel <= addrSel;
        end
    end

    always_comb begin
        case (dataSel)
            ahbPkg::SEL_RAM: begin
                hRdata = ramRdata;
                hReady = ramReady;               // one wait on reads
            end
            ahbPkg::SEL_GPIO: begin
                hRdata = gpioRdata;
                hReady = gpioReady;
            end
            ahbPkg::SEL_DISP: begin
                hRdata = dispRdata;
                hReady = dispReady;
            end
            default: begin
                hRdata = ahbPkg::BAD_DATA;       // unmapped, zero wait
                hReady = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ahbRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbRam #(
    parameter int RAM_WORDS = 1024                      // depth, power of two
) (
    input  logic                      HCLK,
    input  logic                      rst,
    input  logic                      hSel,
    input  logic                      hReady,           // previous transfer done
    input  logic [ahbPkg::ADDR_W-1:0] hAddr,
    input  ahbPkg::htransE            hTrans,
    input  logic                      hWrite,
    input  ahbPkg::hsizeE             hSize,
    input  logic [ahbPkg::DATA_W-1:0] hWdata,
    output logic [ahbPkg::DATA_W-1:0] hRdata,
    output logic                      hReadyOut
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int LANES = ahbPkg::DATA_W / 8;

    logic [ahbPkg::DATA_W-1:0] mem [RAM_WORDS];         // no reset on contents
    logic [IDX_W-1:0]          addrReg;                 // word index, wraps
    logic [LANES-1:0]          laneReg;                 // byte enables, data phase
    logic [LANES-1:0]          laneNext;
    logic                      accept;
    logic                      writePend;
    logic                      readPend;
    logic                      rdValid;                 // read word is out
    logic [ahbPkg::DATA_W-1:0] rdataReg;

    assign accept = hSel && hTrans[1] && hReady;

    // little-endian lanes from size and low address bits
    always_comb begin
        case (hSize)
            ahbPkg::BYTE: laneNext = LANES'(1) << hAddr[1:0];
            ahbPkg::HALF: laneNext = hAddr[1] ? 4'b1100 : 4'b0011;
            default:      laneNext = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            writePend <= 1'b0;
            readPend  <= 1'b0;
            rdValid   <= 1'b0;
        end else begin
            if (hReady) begin
                writePend <= accept && hWrite;
                readPend  <= accept && !hWrite;
            end
            rdValid <= readPend && !rdValid;            // one cycle wait then done
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addrReg <= hAddr[IDX_W+1:2];                // modulo the depth
            laneReg <= laneNext;
        end
    end

    // memory port, write at end of data phase
    always_ff @(posedge HCLK) begin
        if (writePend && hReady) begin
            for (int i = 0; i < LANES; i++) begin
                if (laneReg[i]) mem[addrReg][8*i +: 8] <= hWdata[8*i +: 8];
            end
        end
        if (readPend && !rdValid) rdataReg <= mem[addrReg];
    end

    assign hRdata    = rdataReg;
    assign hReadyOut = !(readPend && !rdValid);         // low in first read cycle

endmodule

`default_nettype wire

// ==== source/ahbGpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbGpio (
    input  logic                      HCLK,
    input  logic                      rst,
    input  logic                      hSel,
    input  logic                      hReady,
    input  logic [ahbPkg::ADDR_W-1:0] hAddr,
    input  ahbPkg::htransE            hTrans,
    input  logic                      hWrite,
    input  logic [ahbPkg::DATA_W-1:0] hWdata,
    input  logic [15:0]               sw,        // slide switches, async
    input  logic [4:0]                btn,       // push buttons, async
    output logic [ahbPkg::DATA_W-1:0] hRdata,
    output logic                      hReadyOut,
    output logic [15:0]               led
);

    ahbPkg::gpioRegE regSel;                     // offset held for data phase
    logic            writePend;
    logic            readyReg;
    logic [15:0]     swMeta;
    logic [15:0]     swSync;
    logic [4:0]      btnMeta;
    logic [4:0]      btnSync;

    ////////////////////////////////////////
    // bus side
    ////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        if (rst) begin
            writePend <= 1'b0;
            readyReg  <= 1'b0;
            led       <= '0;
        end else begin
            readyReg <= 1'b1;                    // never waits once running
            if (hReady) writePend <= hSel && hTrans[1] && hWrite;
            if (writePend && hReady && regSel == ahbPkg::LED_REG)
                led <= hWdata[15:0];             // whole word only
        end
    end

    always_ff @(posedge HCLK) begin
        if (hSel && hTrans[1] && hReady) regSel <= ahbPkg::gpioRegE'(hAddr[3:0]);
    end

    ////////////////////////////////////////
    // input synchronizers
    ////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        swMeta  <= sw;
        swSync  <= swMeta;
        btnMeta <= btn;
        btnSync <= btnMeta;
    end

    always_comb begin
        case (regSel)
            ahbPkg::LED_REG: hRdata = {16'b0, led};
            ahbPkg::SW_REG:  hRdata = {16'b0, swSync};
            ahbPkg::BTN_REG: hRdata = {27'b0, btnSync};
            default:         hRdata = '0;        // unused offset
        endcase
    end

    assign hReadyOut = readyReg;

endmodule

`default_nettype wire

// ==== source/segDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

module segDisplay #(
    parameter int SCAN_DIV = 50000                      // cycles per digit
) (
    input  logic                      HCLK,
    input  logic                      rst,
    input  logic                      hSel,
    input  logic                      hReady,
    input  logic [ahbPkg::ADDR_W-1:0] hAddr,
    input  ahbPkg::htransE            hTrans,
    input  logic                      hWrite,
    input  logic [ahbPkg::DATA_W-1:0] hWdata,
    output logic [ahbPkg::DATA_W-1:0] hRdata,
    output logic                      hReadyOut,
    output logic [7:0]                digit,            // active low, 0 on right
    output logic [7:0]                segment           // active low, ABCDEFGP
);

    localparam int DIV_W = $clog2(SCAN_DIV + 1);

    ahbPkg::dispRegE regSel;
    logic            writePend;
    logic            readyReg;
    logic [31:0]     hexReg;                            // nibble per digit
    logic [7:0]      maskReg;                           // 1 = digit lit
    logic [7:0]      pointReg;
    logic [DIV_W-1:0] prescale;
    logic [2:0]      digitIdx;
    logic [2:0]      nextIdx;

    // abcdefg, active high
    function automatic logic [6:0] hexFont(input logic [3:0] n);
        case (n)
            4'h0: hexFont = 7'h7E;  4'h1: hexFont = 7'h30;
            4'h2: hexFont = 7'h6D;  4'h3: hexFont = 7'h79;
            4'h4: hexFont = 7'h33;  4'h5: hexFont = 7'h5B;
            4'h6: hexFont = 7'h5F;  4'h7: hexFont = 7'h70;
            4'h8: hexFont = 7'h7F;  4'h9: hexFont = 7'h7B;
            4'hA: hexFont = 7'h77;  4'hB: hexFont = 7'h1F;
            4'hC: hexFont = 7'h4E;  4'hD: hexFont = 7'h3D;
            4'hE: hexFont = 7'h4F;  default: hexFont = 7'h47;
        endcase
    endfunction

    ////////////////////////////////////////
    // bus registers
    ////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        if (rst) begin
            writePend <= 1'b0;
            readyReg  <= 1'b0;
            hexReg    <= '0;
            maskReg   <= '0;                            // all digits dark
            pointReg  <= '0;
        end else begin
            readyReg <= 1'b1;
            if (hReady) writePend <= hSel && hTrans[1] && hWrite;
            if (writePend && hReady) begin
                case (regSel)
                    ahbPkg::HEX_REG:   hexReg   <= hWdata;
                    ahbPkg::MASK_REG:  maskReg  <= hWdata[7:0];
                    ahbPkg::POINT_REG: pointReg <= hWdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (hSel && hTrans[1] && hReady) regSel <= ahbPkg::dispRegE'(hAddr[3:0]);
    end

    always_comb begin
        case (regSel)
            ahbPkg::HEX_REG:   hRdata = hexReg;
            ahbPkg::MASK_REG:  hRdata = {24'b0, maskReg};
            ahbPkg::POINT_REG: hRdata = {24'b0, pointReg};
            default:           hRdata = '0;
        endcase
    end

    ////////////////////////////////////////
    // digit scan
    ////////////////////////////////////////
    assign nextIdx = digitIdx + 3'd1;

    always_ff @(posedge HCLK) begin
        if (rst) begin
            prescale <= '0;
            digitIdx <= 3'd7;                           // first slot shows digit 0
            digit    <= 8'hFF;
            segment  <= 8'hFF;
        end else if (prescale == DIV_W'(SCAN_DIV - 1)) begin
            prescale <= '0;
            digitIdx <= nextIdx;
            digit    <= maskReg[nextIdx] ? ~(8'b1 << nextIdx) : 8'hFF;
            segment  <= ~{hexFont(hexReg[4*nextIdx +: 4]), pointReg[nextIdx]};
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    assign hReadyOut = readyReg;

endmodule

`default_nettype wire

// ==== source/ahbSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbSystem #(
    parameter int RAM_WORDS = 1024,                     // ram depth in words
    parameter int SCAN_DIV  = 50000                     // display slot length
) (
    input  logic                      HCLK,             // bus clock
    input  logic                      rst,              // sync, active high
    input  logic [ahbPkg::ADDR_W-1:0] hAddr,            // from master
    input  ahbPkg::htransE            hTrans,
    input  logic                      hWrite,
    input  ahbPkg::hsizeE             hSize,
    input  logic [ahbPkg::DATA_W-1:0] hWdata,
    input  logic [15:0]               sw,
    input  logic [4:0]                btn,
    output logic [ahbPkg::DATA_W-1:0] hRdata,           // to master
    output logic                      hReady,
    output logic [15:0]               led,
    output logic [7:0]                digit,
    output logic [7:0]                segment
);

    ////////////////////////////////////////
    // slave selects and responses
    ////////////////////////////////////////
    logic                      hSelRam;
    logic                      hSelGpio;
    logic                      hSelDisp;
    ahbPkg::slaveSelE          addrSel;                 // decoder to mux
    logic [ahbPkg::DATA_W-1:0] ramRdata;
    logic [ahbPkg::DATA_W-1:0] gpioRdata;
    logic [ahbPkg::DATA_W-1:0] dispRdata;
    logic                      ramReady;
    logic                      gpioReady;
    logic                      dispReady;

    addrDecoder decode (
        .hAddr    (hAddr),
        .hSelRam  (hSelRam),
        .hSelGpio (hSelGpio),
        .hSelDisp (hSelDisp),
        .addrSel  (addrSel)
    );

    responseMux mux (
        .HCLK      (HCLK),
        .rst       (rst),
        .addrSel   (addrSel),
        .ramRdata  (ramRdata),
        .gpioRdata (gpioRdata),
        .dispRdata (dispRdata),
        .ramReady  (ramReady),
        .gpioReady (gpioReady),
        .dispReady (dispReady),
        .hRdata    (hRdata),
        .hReady    (hReady)                             // fed back to slaves
    );

    ahbRam #(.RAM_WORDS(RAM_WORDS)) ram (
        .HCLK (HCLK), .rst (rst), .hSel (hSelRam), .hReady (hReady),
        .hAddr (hAddr), .hTrans (hTrans), .hWrite (hWrite), .hSize (hSize),
        .hWdata (hWdata), .hRdata (ramRdata), .hReadyOut (ramReady)
    );

    ahbGpio gpio (
        .HCLK (HCLK), .rst (rst), .hSel (hSelGpio), .hReady (hReady),
        .hAddr (hAddr), .hTrans (hTrans), .hWrite (hWrite), .hWdata (hWdata),
        .sw (sw), .btn (btn),                           // raw board inputs
        .hRdata (gpioRdata), .hReadyOut (gpioReady), .led (led)
    );

    segDisplay #(.SCAN_DIV(SCAN_DIV)) display (
        .HCLK (HCLK), .rst (rst), .hSel (hSelDisp), .hReady (hReady),
        .hAddr (hAddr), .hTrans (hTrans), .hWrite (hWrite), .hWdata (hWdata),
        .hRdata (dispRdata), .hReadyOut (dispReady),
        .digit (digit), .segment (segment)
    );

endmodule

`default_nettype wire

// ==== dv/busChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module busChecker (
    input  logic                      HCLK,
    input  logic                      rst,
    input  logic [ahbPkg::ADDR_W-1:0] hAddr,
    input  ahbPkg::htransE            hTrans,
    input  logic                      hWrite,
    input  logic [ahbPkg::DATA_W-1:0] hWdata,
    input  logic [ahbPkg::DATA_W-1:0] hRdata,
    input  logic                      hReady,
    input  logic [15:0]               led,
    input  logic [7:0]                digit,
    input  logic [7:0]                segment,
    input  logic                      expStrobe,    // read with an expected value
    input  logic [ahbPkg::DATA_W-1:0] expData,
    input  logic                      dispOn,       // display window open
    output int                        errors
);

    // standard hex font in abcdefg order
    localparam logic [6:0] FONT [16] = '{
        7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
        7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47
    };

    int                        errCount = 0;
    int                        waits;               // hReady low cycles in data phase
    int                        idx;
    logic                      started;
    logic                      dValid;              // data phase in flight
    logic                      dRead;
    logic                      dWrite;
    logic                      dExpOn;
    logic [ahbPkg::DATA_W-1:0] dExp;
    logic [ahbPkg::ADDR_W-1:0] dAddr;
    logic [15:0]               ledModel;
    logic [31:0]               hexModel;
    logic [7:0]                maskModel;
    logic [7:0]                pointModel;
    logic [7:0]                seen;                // digits lit in window
    logic                      wasOn;
    logic [7:0]                expSeg;

    assign errors = errCount;

    task automatic reportValue(input string name, input logic [31:0] expV,
                               input logic [31:0] got);
        errCount++;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, expV, got);
    endtask

    task automatic reportProblem(input string msg);
        errCount++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // sampled mid-cycle when all values have settled
    ////////////////////////////////////////
    always @(negedge HCLK) begin
        if (rst) begin
            started    = 1'b0;
            dValid     = 1'b0;
            ledModel   = '0;
            hexModel   = '0;
            maskModel  = '0;
            pointModel = '0;
            wasOn      = 1'b0;
        end else begin
            if (!started) begin
                if (hReady !== 1'b1) reportValue("hReady", 32'(1), 32'(hReady));
                if (digit !== 8'hFF) reportValue("digit", 32'hFF, 32'(digit));
                started = 1'b1;
            end
            if (led !== ledModel) reportValue("led", 32'(ledModel), 32'(led));
            if (dValid && !hReady) waits++;
            if (dValid && hReady) begin                 // data phase ends at next edge
                if (waits != ((dRead && dAddr[31:24] == ahbPkg::REGION_RAM) ? 1 : 0))
                    reportProblem($sformatf("transfer at %h took %0d wait cycles",
                                            dAddr, waits));
                if (dRead && dExpOn && hRdata !== dExp) reportValue("hRdata", dExp, hRdata);
                if (dWrite && dAddr[31:24] == ahbPkg::REGION_GPIO &&
                    dAddr[3:0] == ahbPkg::LED_REG) ledModel = hWdata[15:0];
                if (dWrite && dAddr[31:24] == ahbPkg::REGION_DISP) begin
                    case (dAddr[3:0])
                        ahbPkg::HEX_REG:   hexModel   = hWdata;
                        ahbPkg::MASK_REG:  maskModel  = hWdata[7:0];
                        ahbPkg::POINT_REG: pointModel = hWdata[7:0];
                        default: ;
                    endcase
                end
            end
            if (hReady) begin                           // address phase accepted
                dValid = hTrans[1];
                dRead  = hTrans[1] && !hWrite;
                dWrite = hTrans[1] && hWrite;
                dExpOn = expStrobe;
                dExp   = expData;
                dAddr  = hAddr;
                waits  = 0;
            end
            if (dispOn) begin
                if (!wasOn) seen = '0;
                if (digit != 8'hFF) begin
                    idx = -1;
                    for (int i = 0; i < 8; i++) begin
                        if (digit == ~(8'b1 << i)) idx = i;
                    end
                    if (idx < 0) begin
                        reportProblem($sformatf("digit lines %b light more than one", digit));
                    end else begin
                        if (!maskModel[idx]) reportProblem($sformatf("masked digit %0d lit", idx));
                        seen[idx] = 1'b1;
                        expSeg = ~{FONT[hexModel[4*idx +: 4]], pointModel[idx]};
                        if (segment !== expSeg) reportValue("segment", 32'(expSeg), 32'(segment));
                    end
                end
            end else if (wasOn && seen !== maskModel) begin
                reportProblem($sformatf("digits lit %b but enabled %b", seen, maskModel));
            end
            wasOn = dispOn;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tbAhbSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbAhbSystem;

    localparam int SCAN_DIV = 4;                        // short scan slots

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_IN, OP_SHOW} opE;

    typedef struct packed {
        opE                        op;
        logic [ahbPkg::ADDR_W-1:0] addr;
        ahbPkg::hsizeE             size;
        logic [ahbPkg::DATA_W-1:0] wdata;
        logic [20:0]               ins;                 // {btn, sw}
        logic [ahbPkg::DATA_W-1:0] expd;                // expected read data
    } rowT;

    logic                      HCLK;
    logic                      rst;
    logic [ahbPkg::ADDR_W-1:0] hAddr;
    ahbPkg::htransE            hTrans;
    logic                      hWrite;
    ahbPkg::hsizeE             hSize;
    logic [ahbPkg::DATA_W-1:0] hWdata;
    logic [15:0]               sw;
    logic [4:0]                btn;
    logic [ahbPkg::DATA_W-1:0] hRdata;
    logic                      hReady;
    logic [15:0]               led;
    logic [7:0]                digit;
    logic [7:0]                segment;
    logic                      expStrobe;
    logic [ahbPkg::DATA_W-1:0] expData;
    logic                      dispOn;
    logic [ahbPkg::DATA_W-1:0] nextWdata;               // for the pending data phase
    int                        errors;
    int                        cycles = 0;
    int                        limit;
    rowT                       rows [$];

    ahbSystem #(.SCAN_DIV(SCAN_DIV)) dut (
        .HCLK (HCLK), .rst (rst), .hAddr (hAddr), .hTrans (hTrans), .hWrite (hWrite),
        .hSize (hSize), .hWdata (hWdata), .sw (sw), .btn (btn), .hRdata (hRdata),
        .hReady (hReady), .led (led), .digit (digit), .segment (segment)
    );

    busChecker check (
        .HCLK (HCLK), .rst (rst), .hAddr (hAddr), .hTrans (hTrans), .hWrite (hWrite),
        .hWdata (hWdata), .hRdata (hRdata),
        .hReady (hReady), .led (led), .digit (digit), .segment (segment),
        .expStrobe (expStrobe), .expData (expData), .dispOn (dispOn), .errors (errors)
    );

    initial begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;
    end

    always @(posedge HCLK) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic addRow(input opE op, input logic [31:0] addr, input ahbPkg::hsizeE size,
                          input logic [31:0] wdata, input logic [20:0] ins,
                          input logic [31:0] expd);
        rows.push_back('{op, addr, size, wdata, ins, expd});
    endtask

    // returns 2 ns after the edge that accepted the address phase
    task automatic waitAccept();
        logic rdy;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge HCLK);
            rdy = hReady;
            @(posedge HCLK);
        end
        #2;
    endtask

    task automatic startTransfer(input rowT r);
        hAddr     = r.addr;
        hTrans    = ahbPkg::NONSEQ;
        hWrite    = (r.op == OP_WR);
        hSize     = r.size;
        hWdata    = nextWdata;                          // data of the transfer before
        expStrobe = (r.op == OP_RD);
        expData   = r.expd;
        waitAccept();
        nextWdata = r.wdata;
    endtask

    task automatic idleBus(input int n);
        hTrans    = ahbPkg::IDLE;
        hWrite    = 1'b0;
        hWdata    = nextWdata;
        expStrobe = 1'b0;
        repeat (n) waitAccept();
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////
    initial begin
        rst = 1'b1;
        hAddr = '0;
        hTrans = ahbPkg::IDLE;
        hWrite = 1'b0;
        hSize = ahbPkg::WORD;
        hWdata = '0;
        sw = '0;
        btn = '0;
        expStrobe = 1'b0;
        expData = '0;
        dispOn = 1'b0;
        nextWdata = '0;
        addRow(OP_WR, 32'h2000_0000, ahbPkg::WORD, 32'h1122_3344, 21'h0, 32'h0);
        addRow(OP_RD, 32'h2000_0000, ahbPkg::WORD, 32'h0, 21'h0, 32'h1122_3344);
        addRow(OP_WR, 32'h2000_0004, ahbPkg::WORD, 32'hA5A5_A5A5, 21'h0, 32'h0);
        addRow(OP_WR, 32'h2000_0005, ahbPkg::BYTE, 32'hFFFF_3CFF, 21'h0, 32'h0);
        addRow(OP_WR, 32'h2000_0006, ahbPkg::HALF, 32'hBEEF_1234, 21'h0, 32'h0);
        addRow(OP_RD, 32'h2000_0004, ahbPkg::WORD, 32'h0, 21'h0, 32'hBEEF_3CA5);
        addRow(OP_WR, 32'h2000_1008, ahbPkg::WORD, 32'hCAFE_F00D, 21'h0, 32'h0); // alias
        addRow(OP_RD, 32'h2000_0008, ahbPkg::WORD, 32'h0, 21'h0, 32'hCAFE_F00D);
        addRow(OP_WR, 32'h5000_0000, ahbPkg::WORD, 32'hFFFF_1234, 21'h0, 32'h0);
        addRow(OP_RD, 32'h5000_0000, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_1234);
        addRow(OP_IN, 32'h0, ahbPkg::WORD, 32'h0, 21'h15BEEF, 32'h0);
        addRow(OP_RD, 32'h5000_0008, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_BEEF);
        addRow(OP_RD, 32'h5000_000C, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_0015);
        addRow(OP_WR, 32'h5000_0008, ahbPkg::WORD, 32'h0, 21'h0, 32'h0);  // read-only
        addRow(OP_WR, 32'h6000_0000, ahbPkg::WORD, 32'h0, 21'h0, 32'h0);  // unmapped
        addRow(OP_RD, 32'h6000_0000, ahbPkg::WORD, 32'h0, 21'h0, ahbPkg::BAD_DATA);
        addRow(OP_RD, 32'h5000_0008, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_BEEF);
        addRow(OP_RD, 32'h5000_0000, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_1234);
        addRow(OP_RD, 32'h2000_0000, ahbPkg::WORD, 32'h0, 21'h0, 32'h1122_3344);
        addRow(OP_WR, 32'h5200_0000, ahbPkg::WORD, 32'h9A3F_0C81, 21'h0, 32'h0);
        addRow(OP_WR, 32'h5200_0004, ahbPkg::WORD, 32'h0000_00B7, 21'h0, 32'h0);
        addRow(OP_WR, 32'h5200_0008, ahbPkg::WORD, 32'h0000_0021, 21'h0, 32'h0);
        addRow(OP_RD, 32'h5200_0000, ahbPkg::WORD, 32'h0, 21'h0, 32'h9A3F_0C81);
        addRow(OP_RD, 32'h5200_0004, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_00B7);
        addRow(OP_RD, 32'h5200_0008, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_0021);
        addRow(OP_SHOW, 32'h0, ahbPkg::WORD, 32'h0, 21'h0, 32'h0);
        addRow(OP_WR, 32'h2000_000C, ahbPkg::WORD, 32'h0BAD_F00D, 21'h0, 32'h0);
        addRow(OP_RD, 32'h5000_0008, ahbPkg::WORD, 32'h0, 21'h0, 32'h0000_BEEF);
        addRow(OP_RD, 32'h2000_000C, ahbPkg::WORD, 32'h0, 21'h0, 32'h0BAD_F00D);
        addRow(OP_RD, 32'h7000_0000, ahbPkg::WORD, 32'h0, 21'h0, ahbPkg::BAD_DATA);
        limit = rows.size() * 6 + 8 * SCAN_DIV * 3 + 20;
        repeat (8) @(posedge HCLK);
        #2 rst = 1'b0;
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_IN: begin
                    sw  = rows[i].ins[15:0];
                    btn = rows[i].ins[20:16];
                    idleBus(3);                         // through both sync flops
                end
                OP_SHOW: begin
                    idleBus(SCAN_DIV + 1);              // one slot to pick up new values
                    dispOn = 1'b1;
                    idleBus(8 * SCAN_DIV + 1);
                    dispOn = 1'b0;
                    idleBus(1);
                end
                default: startTransfer(rows[i]);
            endcase
        end
        idleBus(2);
        @(negedge HCLK);
        #1;                                             // after the checker's last sample
        $display("closing: %0d errors over %0d rows", errors, rows.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/ahbPkg.sv
source/addrDecoder.sv
source/responseMux.sv
source/ahbRam.sv
source/ahbGpio.sv
source/segDisplay.sv
source/ahbSystem.sv
dv/busChecker.sv
dv/tbAhbSystem.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --timescale 1ns/1ps -j 0
TOP   = tbAhbSystem
FLIST = project.f
PASS  = All checks passed

.PHONY: build run clean

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
